// File: logic/zx_ports_params.svh
/* port map, bus widths and reset values of the Spectrum I/O block.
   fixed by the platform; only the low address byte is listed per port */

`ifndef ZX_PORTS_PARAMS_SVH
`define ZX_PORTS_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

`define ZXP_DATA_W      8       // z80 data bus
`define ZXP_ADDR_W      16      // full i/o address
`define ZXP_BORDER_W    4       // border colour incl. bright
`define ZXP_PAGE_W      6       // pentagon-1m page number

//////////////////////////////////////////////////////////////////////
// low address byte of each port
//////////////////////////////////////////////////////////////////////

`define ZXP_PORT_FE     8'hFE   // border, beeper, keyboard
`define ZXP_PORT_FD     8'hFD   // #7FFD paging, needs a15 low
`define ZXP_PORT_F7     8'hF7   // #EFF7 ext paging
`define ZXP_PORT_BF     8'hBF   // config
`define ZXP_PORT_BE     8'hBE   // config readback
`define ZXP_PORT_KJOY   8'h1F   // kempston joystick
`define ZXP_PORT_MOUSE  8'hDF   // kempston mouse
`define ZXP_PORT_SAV1   8'h2F   // shadow scratch
`define ZXP_PORT_SAV2   8'h4F
`define ZXP_PORT_SAV3   8'h6F
`define ZXP_PORT_SAV4   8'h8F

// #BE readback selectors on a[11:8]
`define ZXP_BE_SEL_7FFD 4'hA
`define ZXP_BE_SEL_EFF7 4'hB

//////////////////////////////////////////////////////////////////////
// reset values and idle data
//////////////////////////////////////////////////////////////////////

`define ZXP_BORDER_RST  4'h0
`define ZXP_P7FFD_RST   8'h00   // bit 4 (rom) too, no rom select here
`define ZXP_PEFF7_RST   8'h00
`define ZXP_SAV_RST     8'h00
`define ZXP_IDLE_BYTE   8'hFF   // floating bus read

`endif

// File: logic/zx_ports_pkg.sv
/* shared types of the Spectrum I/O block.
   widths come from the params header */

`include "zx_ports_params.svh"

package zx_ports_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus and register types
	//////////////////////////////////////////////////////////////////////

	typedef logic [`ZXP_DATA_W-1:0]   zx_data_t;    // one data byte
	typedef logic [`ZXP_ADDR_W-1:0]   zx_addr_t;    // full i/o address
	typedef logic [`ZXP_BORDER_W-1:0] zx_border_t;  // {bright, grb}
	typedef logic [`ZXP_PAGE_W-1:0]   zx_page_t;    // 1m page
	typedef logic [1:0]               zx_sav_idx_t; // scratch index, a[6:5]

	//////////////////////////////////////////////////////////////////////
	// decoded port select
	//////////////////////////////////////////////////////////////////////

	// one value per kept port; PS_NONE when nothing in here answers
	typedef enum logic [3:0]
	{
		PS_NONE  = 4'd0,
		PS_FE    = 4'd1,  // border / keys
		PS_7FFD  = 4'd2,  // 128k paging
		PS_EFF7  = 4'd3,  // 1m paging, non-shadow only
		PS_BF    = 4'd4,  // config
		PS_BE    = 4'd5,  // readback
		PS_KJOY  = 4'd6,  // joystick, non-shadow only
		PS_MOUSE = 4'd7,
		PS_SAV   = 4'd8   // shadow-only scratch
	} port_sel_e;

endpackage

// File: logic/z80_io_if.sv
/* strobed z80 i/o access plus decoded port select, shared inside the block.
   addr and data are only valid while the z80 cycle is on */

`timescale 1ns/100ps

interface z80_io_if;

	logic                   wr_stb;  // one zclk per z80 write cycle
	logic                   rd_stb;  // one zclk per z80 read cycle
	zx_ports_pkg::zx_addr_t addr;    // straight from the pins
	zx_ports_pkg::zx_data_t data;    // write data from the pins
	zx_ports_pkg::port_sel_e sel;    // decoded port
	logic                   shadow;  // dos or shadow_en

	// bus side, makes the strobes
	modport sync
	(
		output wr_stb,
		output rd_stb,
		output addr,
		output data
	);

	// address to port select
	modport decode
	(
		input  addr,
		input  shadow,
		output sel
	);

	// write side, owns the shadow state
	modport regs
	(
		input  wr_stb,
		input  addr,
		input  data,
		input  sel,
		output shadow
	);

	// read mux
	modport read
	(
		input  addr,
		input  sel
	);

endinterface

// File: logic/z80_io_sync.sv
/* turns z80 i/o cycles into single zclk strobes.
   bus pins must already be zclk-synchronous; rd and wr both low counts as write */

`timescale 1ns/100ps

module z80_io_sync
(
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  zx_ports_pkg::zx_addr_t a,
	input  zx_ports_pkg::zx_data_t din,
	z80_io_if.sync                 io
);

	logic wr_act;    // i/o write level, combinational
	logic rd_act;    // i/o read level
	logic wr_act_q;  // level seen on previous edge
	logic rd_act_q;

	assign wr_act = ~(iorq_n | wr_n);
	assign rd_act = ~(iorq_n | rd_n);

	// address and data go through untouched, stable during the cycle
	assign io.addr = a;
	assign io.data = din;

	//////////////////////////////////////////////////////////////////////
	// edge detect
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_act_q  <= 1'b0;
			rd_act_q  <= 1'b0;
			io.wr_stb <= 1'b0;
			io.rd_stb <= 1'b0;
		end
		else
		begin
			wr_act_q  <= wr_act;
			rd_act_q  <= rd_act;
			io.wr_stb <= wr_act & ~wr_act_q;            // first edge of the level
			io.rd_stb <= rd_act & ~rd_act_q & ~wr_act;  // write wins a bad overlap
		end
	end

	// level has to drop (iorq_n high) before the next strobe

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// strobes are one cycle wide
	a_stb_single: assert property (@(posedge zclk) disable iff (!rst_n)
		(io.wr_stb || io.rd_stb) |=> !(io.wr_stb || io.rd_stb));

endmodule

// File: logic/zx_port_decode.sv
/* maps the low address byte plus shadow mode onto one port select.
   #FFFD/#BFFD (ay) and all dropped ports decode to PS_NONE */

`timescale 1ns/100ps

`include "zx_ports_params.svh"

module zx_port_decode
(
	z80_io_if.decode io
);

	zx_ports_pkg::zx_data_t loa;  // low address byte

	assign loa = io.addr[7:0];

	//////////////////////////////////////////////////////////////////////
	// port map
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		io.sel = zx_ports_pkg::PS_NONE;
		case (loa)
			`ZXP_PORT_FE:
				io.sel = zx_ports_pkg::PS_FE;
			`ZXP_PORT_FD:
			begin
				if (!io.addr[15])  // 7FFD only, a15 high is ay
					io.sel = zx_ports_pkg::PS_7FFD;
			end
			`ZXP_PORT_F7:
			begin
				// EFF7 pattern, gone in shadow mode
				if (io.addr[8] && !io.addr[12] && !io.shadow)
					io.sel = zx_ports_pkg::PS_EFF7;
			end
			`ZXP_PORT_BF:
				io.sel = zx_ports_pkg::PS_BF;
			`ZXP_PORT_BE:
				io.sel = zx_ports_pkg::PS_BE;
			`ZXP_PORT_KJOY:
			begin
				if (!io.shadow)  // #1F is vg93 cmd in shadow
					io.sel = zx_ports_pkg::PS_KJOY;
			end
			`ZXP_PORT_MOUSE:
				io.sel = zx_ports_pkg::PS_MOUSE;
			`ZXP_PORT_SAV1, `ZXP_PORT_SAV2, `ZXP_PORT_SAV3, `ZXP_PORT_SAV4:
			begin
				if (io.shadow)  // dos-only scratch
					io.sel = zx_ports_pkg::PS_SAV;
			end
			default:
				io.sel = zx_ports_pkg::PS_NONE;
		endcase
	end

endmodule

// File: logic/zx_port_regs.sv
/* writable port registers, updated on the edge that ends wr_stb.
   #7FFD is frozen while its bit 5 and #EFF7 bit 2 are both set */

`timescale 1ns/100ps

`include "zx_ports_params.svh"

module zx_port_regs
(
	input  logic                     zclk,
	input  logic                     rst_n,
	input  logic                     dos,
	z80_io_if.regs                   io,
	output zx_ports_pkg::zx_border_t border,
	output zx_ports_pkg::zx_data_t   p7ffd,
	output zx_ports_pkg::zx_data_t   peff7,
	output zx_ports_pkg::zx_page_t   pent1m_page,
	output logic                     romrw_en,
	output logic                     set_nmi,
	output zx_ports_pkg::zx_data_t   sav_rd,
	output zx_ports_pkg::zx_data_t   p7ffd_raw,
	output zx_ports_pkg::zx_data_t   peff7_raw,
	output logic [3:0]               cfg_bits    // #BF readback
);

	zx_ports_pkg::zx_data_t    p7ffd_q;  // 2..0 page, 3 screen, 4 rom, 5 48k lock, 7..6 1m
	zx_ports_pkg::zx_data_t    peff7_q;  // 2 block1m, rest passed out
	logic                      shadow_en;
	logic                      fnt_en;   // font ram write enable
	zx_ports_pkg::zx_data_t    sav_q [4];
	zx_ports_pkg::zx_sav_idx_t sav_idx;
	logic                      block1m;
	logic                      lock7ffd;

	assign block1m  = peff7_q[2];
	assign lock7ffd = p7ffd_q[5] & block1m;  // 48k lock, only in 128k mode
	assign sav_idx  = io.addr[6:5];          // 2F/4F/6F/8F -> 1/2/3/0

	//////////////////////////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border    <= `ZXP_BORDER_RST;
			p7ffd_q   <= `ZXP_P7FFD_RST;
			peff7_q   <= `ZXP_PEFF7_RST;
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			fnt_en    <= 1'b0;
			set_nmi   <= 1'b0;
			for (int i = 0; i < 4; i++)
				sav_q[i] <= `ZXP_SAV_RST;
		end
		else if (io.wr_stb)
		begin
			case (io.sel)
				zx_ports_pkg::PS_FE:
					border <= {~io.addr[3], io.data[2:0]};  // bright from a3, inverted
				zx_ports_pkg::PS_7FFD:
				begin
					if (!lock7ffd)
						p7ffd_q <= io.data;
				end
				zx_ports_pkg::PS_EFF7:
					peff7_q <= io.data;
				zx_ports_pkg::PS_BF:
				begin
					shadow_en <= io.data[0];
					romrw_en  <= io.data[1];
					fnt_en    <= io.data[2];
					set_nmi   <= io.data[3];
				end
				zx_ports_pkg::PS_SAV:
					sav_q[sav_idx] <= io.data;  // decode already checked shadow
				default:
				begin
					// read-only or foreign port, nothing stored
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// derived outputs
	//////////////////////////////////////////////////////////////////////

	assign io.shadow   = dos | shadow_en;
	assign pent1m_page = {p7ffd_q[7:5], p7ffd_q[2:0]};

	// 128k mode hides the 1m bits
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
	assign peff7 = block1m ?
		{peff7_q[7], 1'b0, peff7_q[5], peff7_q[4], 3'b000, peff7_q[0]} : peff7_q;

	assign p7ffd_raw = p7ffd_q;
	assign peff7_raw = peff7_q;
	assign sav_rd    = sav_q[sav_idx];
	assign cfg_bits  = {set_nmi, fnt_en, romrw_en, shadow_en};

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// scratch writes only ever arrive in shadow mode
	a_sav_shadow: assert property (@(posedge zclk) disable iff (!rst_n)
		(io.wr_stb && io.sel == zx_ports_pkg::PS_SAV) |-> io.shadow);

endmodule

// File: logic/zx_port_read.sv
/* combinational read data, answered within the z80 cycle.
   #BE only reads back 7FFD (a[11:8]=A) and EFF7 (B), others give #FF */

`timescale 1ns/100ps

`include "zx_ports_params.svh"

module zx_port_read
(
	z80_io_if.read                 io,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic [4:0]             keys_in,    // active low keys
	input  logic [4:0]             kj_in,      // kempston bits
	input  logic                   tape_read,
	input  zx_ports_pkg::zx_data_t mus_in,
	input  zx_ports_pkg::zx_data_t p7ffd_raw,
	input  zx_ports_pkg::zx_data_t peff7_raw,
	input  zx_ports_pkg::zx_data_t sav_rd,
	input  logic [3:0]             cfg_bits,   // {nmi, font, romrw, shadow}
	output zx_ports_pkg::zx_data_t dout,
	output logic                   porthit,
	output logic                   dataout
);

	zx_ports_pkg::zx_data_t be_mux;  // #BE readback byte

	//////////////////////////////////////////////////////////////////////
	// #BE selector
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (io.addr[11:8])
			`ZXP_BE_SEL_7FFD: be_mux = p7ffd_raw;  // unmasked, lock bits included
			`ZXP_BE_SEL_EFF7: be_mux = peff7_raw;
			default:          be_mux = `ZXP_IDLE_BYTE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// read mux
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (io.sel)
			zx_ports_pkg::PS_FE:    dout = {1'b1, tape_read, 1'b0, keys_in};
			zx_ports_pkg::PS_KJOY:  dout = {3'b000, kj_in};
			zx_ports_pkg::PS_MOUSE: dout = mus_in;
			zx_ports_pkg::PS_BF:    dout = {4'b0000, cfg_bits};
			zx_ports_pkg::PS_BE:    dout = be_mux;
			zx_ports_pkg::PS_SAV:   dout = sav_rd;
			default:                dout = `ZXP_IDLE_BYTE;  // write-only 7FFD/EFF7 too
		endcase
	end

	// any decoded port counts, even write-only ones
	assign porthit = (io.sel != zx_ports_pkg::PS_NONE);
	assign dataout = porthit & ~iorq_n & ~rd_n;  // drive bus only on our reads

endmodule

// File: logic/zx_ports_top.sv
/* port-decoding core of the i/o block, everything on zclk.
   no ay, ide, sd or atm ports; their addresses read as not hit */

`timescale 1ns/100ps

module zx_ports_top
(
	input  logic                     zclk,
	input  logic                     rst_n,
	input  zx_ports_pkg::zx_addr_t   a,
	input  zx_ports_pkg::zx_data_t   din,
	input  logic                     iorq_n,
	input  logic                     rd_n,
	input  logic                     wr_n,
	input  logic                     dos,
	input  logic [4:0]               keys_in,
	input  logic [4:0]               kj_in,
	input  zx_ports_pkg::zx_data_t   mus_in,
	input  logic                     tape_read,
	output zx_ports_pkg::zx_data_t   dout,
	output logic                     dataout,
	output logic                     porthit,
	output zx_ports_pkg::zx_border_t border,
	output zx_ports_pkg::zx_data_t   p7ffd,
	output zx_ports_pkg::zx_data_t   peff7,
	output zx_ports_pkg::zx_page_t   pent1m_page,
	output logic                     romrw_en,
	output logic                     set_nmi
);

	zx_ports_pkg::zx_data_t sav_rd;     // scratch byte at current address
	zx_ports_pkg::zx_data_t p7ffd_raw;  // unmasked, for #BE
	zx_ports_pkg::zx_data_t peff7_raw;
	logic [3:0]             cfg_bits;   // #BF readback

	z80_io_if io();

	z80_io_sync u_sync (.zclk(zclk), .rst_n(rst_n), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .a(a), .din(din), .io(io.sync));

	zx_port_decode u_decode (.io(io.decode));

	zx_port_regs u_regs (.zclk(zclk), .rst_n(rst_n), .dos(dos), .io(io.regs),
		.border(border), .p7ffd(p7ffd), .peff7(peff7), .pent1m_page(pent1m_page),
		.romrw_en(romrw_en), .set_nmi(set_nmi), .sav_rd(sav_rd),
		.p7ffd_raw(p7ffd_raw), .peff7_raw(peff7_raw), .cfg_bits(cfg_bits));

	zx_port_read u_read (.io(io.read), .iorq_n(iorq_n), .rd_n(rd_n),
		.keys_in(keys_in), .kj_in(kj_in), .tape_read(tape_read), .mus_in(mus_in),
		.p7ffd_raw(p7ffd_raw), .peff7_raw(peff7_raw), .sav_rd(sav_rd),
		.cfg_bits(cfg_bits), .dout(dout), .porthit(porthit), .dataout(dataout));

endmodule

// File: tb/zx_ports_tb.sv
/* random z80 i/o cycles against a model of the port registers.
   each bus cycle holds iorq low for 3 zclk then high for 1; stops at first mismatch */

`timescale 1ns/100ps

`include "zx_ports_params.svh"

module zx_ports_tb;

	localparam int NUM_OPS     = 400;                     // bus cycles after reset
	localparam int CYCLE_LIMIT = 4 * (NUM_OPS * 4 + 10);  // generous upper bound

	logic zclk, rst_n, iorq_n, rd_n, wr_n, dos, tape_read;
	logic [4:0] keys_in, kj_in;
	zx_ports_pkg::zx_addr_t a;
	zx_ports_pkg::zx_data_t din, mus_in, dout, p7ffd, peff7;
	zx_ports_pkg::zx_border_t border;
	zx_ports_pkg::zx_page_t pent1m_page;
	logic dataout, porthit, romrw_en, set_nmi;

	// model state
	zx_ports_pkg::zx_data_t m_7ffd, m_eff7;
	zx_ports_pkg::zx_border_t m_border;
	logic m_shadow_en, m_romrw, m_fnt, m_nmi;
	zx_ports_pkg::zx_data_t m_sav [4];
	int cycles = 0;

	zx_ports_top UUT (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .dos(dos), .keys_in(keys_in), .kj_in(kj_in),
		.mus_in(mus_in), .tape_read(tape_read), .dout(dout), .dataout(dataout),
		.porthit(porthit), .border(border), .p7ffd(p7ffd), .peff7(peff7),
		.pent1m_page(pent1m_page), .romrw_en(romrw_en), .set_nmi(set_nmi));

	initial
	begin
		zclk = 1'b0;
		forever #10 zclk = ~zclk;  // 20 ns period
	end

	always @(posedge zclk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run timed out after %0d clock cycles", cycles);
			stop_with_failure("timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, why);
	endtask

	task automatic check_data(input string name, input zx_ports_pkg::zx_data_t exp,
		input zx_ports_pkg::zx_data_t act);
		if (act !== exp)
		begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			stop_with_failure("data mismatch");
		end
	endtask

	task automatic check_border(input string name, input zx_ports_pkg::zx_border_t exp,
		input zx_ports_pkg::zx_border_t act);
		if (act !== exp)
		begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			stop_with_failure("border mismatch");
		end
	endtask

	task automatic check_page(input string name, input zx_ports_pkg::zx_page_t exp,
		input zx_ports_pkg::zx_page_t act);
		if (act !== exp)
		begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			stop_with_failure("page mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			stop_with_failure("bit mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic zx_ports_pkg::port_sel_e model_sel(input zx_ports_pkg::zx_addr_t addr,
		input logic shadow);
		logic [7:0] lo;
		lo = addr[7:0];
		if (lo == `ZXP_PORT_FE) return zx_ports_pkg::PS_FE;
		if (lo == `ZXP_PORT_FD && !addr[15]) return zx_ports_pkg::PS_7FFD;
		if (lo == `ZXP_PORT_F7 && addr[8] && !addr[12] && !shadow)
			return zx_ports_pkg::PS_EFF7;
		if (lo == `ZXP_PORT_BF) return zx_ports_pkg::PS_BF;
		if (lo == `ZXP_PORT_BE) return zx_ports_pkg::PS_BE;
		if (lo == `ZXP_PORT_KJOY && !shadow) return zx_ports_pkg::PS_KJOY;  // vg93 in dos
		if (lo == `ZXP_PORT_MOUSE) return zx_ports_pkg::PS_MOUSE;
		if (shadow && (lo == `ZXP_PORT_SAV1 || lo == `ZXP_PORT_SAV2 ||
			lo == `ZXP_PORT_SAV3 || lo == `ZXP_PORT_SAV4))
			return zx_ports_pkg::PS_SAV;
		return zx_ports_pkg::PS_NONE;
	endfunction

	function automatic zx_ports_pkg::zx_data_t model_read(input zx_ports_pkg::zx_addr_t addr,
		input zx_ports_pkg::port_sel_e sel);
		case (sel)
			zx_ports_pkg::PS_FE:    return {1'b1, tape_read, 1'b0, keys_in};
			zx_ports_pkg::PS_KJOY:  return {3'b000, kj_in};
			zx_ports_pkg::PS_MOUSE: return mus_in;
			zx_ports_pkg::PS_BF:    return {4'h0, m_nmi, m_fnt, m_romrw, m_shadow_en};
			zx_ports_pkg::PS_SAV:   return m_sav[addr[6:5]];
			zx_ports_pkg::PS_BE:
			begin
				if (addr[11:8] == 4'hA) return m_7ffd;  // raw, lock bits too
				if (addr[11:8] == 4'hB) return m_eff7;
				return 8'hFF;
			end
			default:                return 8'hFF;   // write-only or no port
		endcase
	endfunction

	task automatic model_write(input zx_ports_pkg::zx_addr_t addr,
		input zx_ports_pkg::zx_data_t data, input zx_ports_pkg::port_sel_e sel);
		case (sel)
			zx_ports_pkg::PS_FE:   m_border = {~addr[3], data[2:0]};
			zx_ports_pkg::PS_7FFD:
			begin
				if (!(m_7ffd[5] && m_eff7[2]))  // 48k lock in 128k mode
					m_7ffd = data;
			end
			zx_ports_pkg::PS_EFF7: m_eff7 = data;
			zx_ports_pkg::PS_BF:   {m_nmi, m_fnt, m_romrw, m_shadow_en} = data[3:0];
			zx_ports_pkg::PS_SAV:  m_sav[addr[6:5]] = data;
			default:
			begin
				// nothing stored
			end
		endcase
	endtask

	task automatic check_outputs();
		logic blk;
		blk = m_eff7[2];  // block1m
		check_border("border", m_border, border);
		check_data("p7ffd", blk ? {3'b000, m_7ffd[4:0]} : m_7ffd, p7ffd);
		check_data("peff7", blk ? (m_eff7 & 8'hB1) : m_eff7, peff7);  // keeps 7,5,4,0
		check_page("pent1m_page", {m_7ffd[7:5], m_7ffd[2:0]}, pent1m_page);
		check_bit("romrw_en", m_romrw, romrw_en);
		check_bit("set_nmi", m_nmi, set_nmi);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// mostly kept ports, with the upper byte steered now and then
	function automatic zx_ports_pkg::zx_addr_t rand_addr();
		logic [7:0] hi;
		logic [3:0] be_sel;
		hi = 8'($urandom);
		be_sel = ($urandom % 3 == 0) ? 4'hA : (($urandom % 2) ? 4'hB : hi[3:0]);
		case ($urandom % 12)
			0:  return {hi, `ZXP_PORT_FE};
			1:  return {hi & 8'h7F, `ZXP_PORT_FD};
			2:  return {(($urandom % 2) ? 8'hEF : hi), `ZXP_PORT_F7};
			3:  return {hi, `ZXP_PORT_BF};
			4:  return {hi[7:4], be_sel, `ZXP_PORT_BE};
			5:  return {hi, `ZXP_PORT_KJOY};
			6:  return {hi, `ZXP_PORT_MOUSE};
			7:  return {hi, `ZXP_PORT_SAV1};
			8:  return {hi, `ZXP_PORT_SAV2};
			9:  return {hi, `ZXP_PORT_SAV3};
			10: return {hi, `ZXP_PORT_SAV4};
			default: return {hi, 8'($urandom)};  // random low byte
		endcase
	endfunction

	// one z80 i/o cycle: iorq low 3 clocks, high 1
	task automatic bus_cycle(input logic is_wr, input zx_ports_pkg::zx_addr_t addr,
		input zx_ports_pkg::zx_data_t data, input logic dos_v);
		zx_ports_pkg::port_sel_e sel;
		@(posedge zclk);
		a         <= addr;
		din       <= data;
		dos       <= dos_v;
		iorq_n    <= 1'b0;
		wr_n      <= !is_wr;
		rd_n      <= is_wr;
		keys_in   <= 5'($urandom);
		kj_in     <= 5'($urandom);
		mus_in    <= 8'($urandom);
		tape_read <= 1'($urandom);
		@(posedge zclk);  // first edge to see the cycle
		@(negedge zclk);
		sel = model_sel(addr, dos_v | m_shadow_en);
		check_bit("porthit", sel != zx_ports_pkg::PS_NONE, porthit);
		check_bit("dataout", !is_wr && sel != zx_ports_pkg::PS_NONE, dataout);
		if (is_wr)
			model_write(addr, data, sel);
		else
			check_data("dout", model_read(addr, sel), dout);
		@(posedge zclk);  // registers load here
		@(negedge zclk);
		check_outputs();
		@(posedge zclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		@(negedge zclk);
		check_bit("dataout", 1'b0, dataout);  // idle bus
	endtask

	initial
	begin
		void'($urandom(32'h30d5));
		rst_n = 1'b0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dos = 1'b0;
		a = '0;
		din = '0;
		keys_in = '1;
		kj_in = '0;
		mus_in = '0;
		tape_read = 1'b0;
		m_7ffd = 8'h00;
		m_eff7 = 8'h00;
		m_border = 4'h0;
		{m_shadow_en, m_romrw, m_fnt, m_nmi} = 4'h0;
		for (int i = 0; i < 4; i++)
			m_sav[i] = 8'h00;
		repeat (4) @(posedge zclk);
		rst_n <= 1'b1;
		@(negedge zclk);
		check_outputs();  // reset values
		check_bit("dataout", 1'b0, dataout);
		for (int n = 0; n < NUM_OPS; n++)
			bus_cycle(1'($urandom), rand_addr(), 8'($urandom), 1'($urandom));
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+logic
logic/zx_ports_pkg.sv
logic/z80_io_if.sv
logic/z80_io_sync.sv
logic/zx_port_decode.sv
logic/zx_port_regs.sv
logic/zx_port_read.sv
logic/zx_ports_top.sv
tb/zx_ports_tb.sv
